/* Bender.yml */
package:
  name: l2_mem_port

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/l2_axi_pkg.sv
      - hw/l2_burst_if.sv
      - hw/l2_line_engine.sv
      - hw/l2_axi_interface.sv
      - hw/l2_bus_status.sv
      - hw/l2_mem_port.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/l2_mem_port_checker.sv
      - testbench/tb_l2_mem_port.sv

/* hw/l2_axi_interface.sv */
// AXI bridge for L2 line traffic
// read and write channels run in parallel
`include "l2_axi_settings.svh"

module l2_axi_interface (
    input  logic              clk,
    input  logic              rstn,
    input  l2_axi_pkg::word_t fill_word,
    output logic              rd_err_pulse,
    output logic              wr_err_pulse,
    // AR
    output l2_axi_pkg::addr_t araddr,
    output logic              arvalid,
    input  logic              arready,
    // R
    input  l2_axi_pkg::word_t rdata,
    input  logic [1:0]        rresp,
    input  logic              rvalid,
    output logic              rready,
    input  logic              rlast,
    // AW
    output l2_axi_pkg::addr_t awaddr,
    output logic              awvalid,
    input  logic              awready,
    // W
    output l2_axi_pkg::word_t wdata,
    output logic              wvalid,
    input  logic              wready,
    output logic              wlast,
    // B
    input  logic [1:0]        bresp,
    input  logic              bvalid,
    output logic              bready,
    l2_burst_if.bridge        bus
);
    import l2_axi_pkg::*;

    localparam int BEAT_W = $clog2(`L2_LINE_BEATS);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`L2_LINE_BEATS - 1);

    rd_state_t         rd_state;
    rd_state_t         rd_next;
    wr_state_t         wr_state;
    wr_state_t         wr_next;
    logic [BEAT_W-1:0] beat_cnt;
    logic              r_hs;
    logic              w_hs;
    logic              b_hs;

    always_ff @(posedge clk) begin
        if (!rstn)
            rd_state <= RD_IDLE;
        else
            rd_state <= rd_next;
    end

    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            RD_IDLE: if (bus.rd_start) rd_next = RD_ADDR;
            RD_ADDR: if (arready) rd_next = RD_DATA;
            RD_DATA: if (r_hs && rlast) rd_next = RD_IDLE;
            default: rd_next = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (bus.rd_start)
            araddr <= bus.rd_addr;
    end

    assign arvalid = (rd_state == RD_ADDR);
    assign rready  = (rd_state == RD_DATA);
    assign r_hs    = rvalid && rready;

    // error beats carry the fill word instead of bus data
    assign bus.rd_beat_valid = r_hs;
    assign bus.rd_beat_err   = rresp[1];
    assign bus.rd_beat_data  = rresp[1] ? fill_word : rdata;
    assign bus.rd_beat_last  = rlast;
    assign rd_err_pulse      = r_hs && rresp[1];

    always_ff @(posedge clk) begin
        if (!rstn)
            wr_state <= WR_IDLE;
        else
            wr_state <= wr_next;
    end

    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            WR_IDLE: if (bus.wr_start) wr_next = WR_ADDR;
            WR_ADDR: if (awready) wr_next = WR_DATA;
            WR_DATA: if (w_hs && wlast) wr_next = WR_RESP;
            WR_RESP: if (b_hs) wr_next = WR_IDLE;
            default: wr_next = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (bus.wr_start)
            awaddr <= bus.wr_addr;
    end

    // W beat counter for wlast
    always_ff @(posedge clk) begin
        if (!rstn)
            beat_cnt <= '0;
        else if (bus.wr_start)
            beat_cnt <= '0;
        else if (w_hs)
            beat_cnt <= beat_cnt + 1'b1;
    end

    assign awvalid = (wr_state == WR_ADDR);
    assign wvalid  = (wr_state == WR_DATA);
    assign wlast   = wvalid && (beat_cnt == LAST_BEAT);
    assign wdata   = bus.wr_data;
    assign bready  = (wr_state == WR_RESP);
    assign w_hs    = wvalid && wready;
    assign b_hs    = bvalid && bready;

    assign bus.wr_beat_take = w_hs;
    assign bus.wr_done      = b_hs;
    assign bus.wr_err       = bresp[1];
    assign wr_err_pulse     = b_hs && bresp[1];

endmodule

/* hw/l2_axi_pkg.sv */
// L2 memory port types
`include "l2_axi_settings.svh"

package l2_axi_pkg;

    typedef logic [31:0] addr_t;                                  // byte address
    typedef logic [`L2_WORD_W-1:0] word_t;
    typedef logic [`L2_WORD_W*`L2_LINE_BEATS-1:0] line_t;         // word 0 in low bits
    typedef logic [15:0] err_cnt_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

endpackage

/* hw/l2_axi_settings.svh */
// L2 memory port geometry
`ifndef L2_AXI_SETTINGS_SVH
`define L2_AXI_SETTINGS_SVH

// bits per AXI data beat
`define L2_WORD_W 32

// beats per cache line, one INCR burst
`define L2_LINE_BEATS 4

// fill word after reset
`define L2_FILL_RESET 32'hABCD1234

`endif

/* hw/l2_burst_if.sv */
// beat traffic between line engine and AXI bridge

interface l2_burst_if;
    import l2_axi_pkg::*;

    // read side
    logic  rd_start;
    addr_t rd_addr;
    logic  rd_beat_valid;    // one cycle per R beat
    word_t rd_beat_data;
    logic  rd_beat_err;
    logic  rd_beat_last;

    // write side
    logic  wr_start;
    addr_t wr_addr;
    word_t wr_data;
    logic  wr_beat_take;     // W beat accepted
    logic  wr_done;
    logic  wr_err;

    modport engine (
        output rd_start,
        output rd_addr,
        input  rd_beat_valid,
        input  rd_beat_data,
        input  rd_beat_err,
        input  rd_beat_last,
        output wr_start,
        output wr_addr,
        output wr_data,
        input  wr_beat_take,
        input  wr_done,
        input  wr_err
    );

    modport bridge (
        input  rd_start,
        input  rd_addr,
        output rd_beat_valid,
        output rd_beat_data,
        output rd_beat_err,
        output rd_beat_last,
        input  wr_start,
        input  wr_addr,
        input  wr_data,
        output wr_beat_take,
        output wr_done,
        output wr_err
    );

endinterface

/* hw/l2_bus_status.sv */
// fill word and error counters
`include "l2_axi_settings.svh"

module l2_bus_status (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 cfg_fill_we,
    input  l2_axi_pkg::word_t    cfg_fill_data,
    input  logic                 rd_err_pulse,
    input  logic                 wr_err_pulse,
    output l2_axi_pkg::word_t    fill_word,
    output l2_axi_pkg::err_cnt_t rd_err_cnt,
    output l2_axi_pkg::err_cnt_t wr_err_cnt
);
    import l2_axi_pkg::*;

    localparam err_cnt_t CNT_MAX = '1;

    always_ff @(posedge clk) begin
        if (!rstn)
            fill_word <= `L2_FILL_RESET;
        else if (cfg_fill_we)
            fill_word <= cfg_fill_data;
    end

    // counters stick at max
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_err_cnt <= '0;
            wr_err_cnt <= '0;
        end else begin
            if (rd_err_pulse && rd_err_cnt != CNT_MAX)
                rd_err_cnt <= rd_err_cnt + 1'b1;
            if (wr_err_pulse && wr_err_cnt != CNT_MAX)
                wr_err_cnt <= wr_err_cnt + 1'b1;
        end
    end

endmodule

/* hw/l2_line_engine.sv */
// L2 line engine
// refill collection and writeback streaming
`include "l2_axi_settings.svh"

module l2_line_engine (
    input  logic              clk,
    input  logic              rstn,
    input  logic              refill_req,
    input  l2_axi_pkg::addr_t refill_addr,
    input  logic              wb_req,
    input  l2_axi_pkg::addr_t wb_addr,
    input  l2_axi_pkg::line_t wb_line,
    output logic              refill_busy,
    output logic              refill_done,
    output l2_axi_pkg::line_t refill_line,
    output logic              refill_err,
    output logic              wb_busy,
    output logic              wb_done,
    output logic              wb_err,
    l2_burst_if.engine        bus
);
    import l2_axi_pkg::*;

    localparam int WORD_W = `L2_WORD_W;
    localparam int LINE_W = WORD_W * `L2_LINE_BEATS;
    localparam int LINE_BYTES = WORD_W / 8 * `L2_LINE_BEATS;
    localparam addr_t LINE_MASK = ~addr_t'(LINE_BYTES - 1);

    line_t rd_shift;     // beats collected so far
    logic  rd_err_acc;
    line_t wb_shift;     // low word is the next W beat
    logic  refill_take;
    logic  wb_take;

    assign refill_take = refill_req && !refill_busy;
    assign wb_take = wb_req && !wb_busy;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            refill_busy  <= 1'b0;
            refill_done  <= 1'b0;
            refill_err   <= 1'b0;
            rd_err_acc   <= 1'b0;
            bus.rd_start <= 1'b0;
        end else begin
            bus.rd_start <= refill_take;
            refill_done  <= 1'b0;
            if (refill_take) begin
                refill_busy <= 1'b1;
                rd_err_acc  <= 1'b0;
            end else if (bus.rd_beat_valid) begin
                rd_err_acc <= rd_err_acc | bus.rd_beat_err;
                if (bus.rd_beat_last) begin
                    refill_busy <= 1'b0;
                    refill_done <= 1'b1;
                    refill_err  <= rd_err_acc | bus.rd_beat_err;
                end
            end
        end
    end

    // refill data path
    always_ff @(posedge clk) begin
        if (refill_take)
            bus.rd_addr <= refill_addr & LINE_MASK;
        if (bus.rd_beat_valid) begin
            rd_shift <= {bus.rd_beat_data, rd_shift[LINE_W-1:WORD_W]};
            if (bus.rd_beat_last)
                refill_line <= {bus.rd_beat_data, rd_shift[LINE_W-1:WORD_W]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_busy      <= 1'b0;
            wb_done      <= 1'b0;
            wb_err       <= 1'b0;
            bus.wr_start <= 1'b0;
        end else begin
            bus.wr_start <= wb_take;
            wb_done      <= 1'b0;
            if (wb_take) begin
                wb_busy <= 1'b1;
            end else if (bus.wr_done) begin
                wb_busy <= 1'b0;
                wb_done <= 1'b1;
                wb_err  <= bus.wr_err;
            end
        end
    end

    // writeback data path
    always_ff @(posedge clk) begin
        if (wb_take) begin
            bus.wr_addr <= wb_addr & LINE_MASK;
            wb_shift    <= wb_line;
        end else if (bus.wr_beat_take) begin
            wb_shift <= {{WORD_W{1'b0}}, wb_shift[LINE_W-1:WORD_W]};
        end
    end

    assign bus.wr_data = wb_shift[WORD_W-1:0];

endmodule

/* hw/l2_mem_port.sv */
// L2 memory port top

module l2_mem_port (
    input  logic                 clk,
    input  logic                 rstn,
    // refill
    input  logic                 refill_req,
    input  l2_axi_pkg::addr_t    refill_addr,
    output logic                 refill_busy,
    output logic                 refill_done,
    output l2_axi_pkg::line_t    refill_line,
    output logic                 refill_err,
    // writeback
    input  logic                 wb_req,
    input  l2_axi_pkg::addr_t    wb_addr,
    input  l2_axi_pkg::line_t    wb_line,
    output logic                 wb_busy,
    output logic                 wb_done,
    output logic                 wb_err,
    // config and status
    input  logic                 cfg_fill_we,
    input  l2_axi_pkg::word_t    cfg_fill_data,
    output l2_axi_pkg::err_cnt_t rd_err_cnt,
    output l2_axi_pkg::err_cnt_t wr_err_cnt,
    // AXI
    output l2_axi_pkg::addr_t    araddr,
    output logic                 arvalid,
    input  logic                 arready,
    input  l2_axi_pkg::word_t    rdata,
    input  logic [1:0]           rresp,
    input  logic                 rvalid,
    output logic                 rready,
    input  logic                 rlast,
    output l2_axi_pkg::addr_t    awaddr,
    output logic                 awvalid,
    input  logic                 awready,
    output l2_axi_pkg::word_t    wdata,
    output logic                 wvalid,
    input  logic                 wready,
    output logic                 wlast,
    input  logic [1:0]           bresp,
    input  logic                 bvalid,
    output logic                 bready
);
    import l2_axi_pkg::*;

    word_t fill_word;
    logic  rd_err_pulse;
    logic  wr_err_pulse;

    l2_burst_if burst ();

    l2_line_engine u_engine (
        .clk         (clk),
        .rstn        (rstn),
        .refill_req  (refill_req),
        .refill_addr (refill_addr),
        .wb_req      (wb_req),
        .wb_addr     (wb_addr),
        .wb_line     (wb_line),
        .refill_busy (refill_busy),
        .refill_done (refill_done),
        .refill_line (refill_line),
        .refill_err  (refill_err),
        .wb_busy     (wb_busy),
        .wb_done     (wb_done),
        .wb_err      (wb_err),
        .bus         (burst.engine)
    );

    l2_axi_interface u_bridge (
        .clk          (clk),
        .rstn         (rstn),
        .fill_word    (fill_word),
        .rd_err_pulse (rd_err_pulse),
        .wr_err_pulse (wr_err_pulse),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .rlast        (rlast),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .wready       (wready),
        .wlast        (wlast),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .bus          (burst.bridge)
    );

    l2_bus_status u_status (
        .clk           (clk),
        .rstn          (rstn),
        .cfg_fill_we   (cfg_fill_we),
        .cfg_fill_data (cfg_fill_data),
        .rd_err_pulse  (rd_err_pulse),
        .wr_err_pulse  (wr_err_pulse),
        .fill_word     (fill_word),
        .rd_err_cnt    (rd_err_cnt),
        .wr_err_cnt    (wr_err_cnt)
    );

endmodule

/* sim.f */
+incdir+hw
hw/l2_axi_pkg.sv
hw/l2_burst_if.sv
hw/l2_line_engine.sv
hw/l2_axi_interface.sv
hw/l2_bus_status.sv
hw/l2_mem_port.sv
testbench/l2_mem_port_checker.sv
testbench/tb_l2_mem_port.sv

/* testbench/l2_mem_port_checker.sv */
// AXI protocol checks
`include "l2_axi_settings.svh"

module l2_mem_port_checker (
    input logic              clk,
    input logic              rstn,
    input l2_axi_pkg::addr_t araddr,
    input logic              arvalid,
    input logic              arready,
    input l2_axi_pkg::addr_t awaddr,
    input logic              awvalid,
    input logic              awready,
    input logic              wvalid,
    input logic              wready,
    input logic              wlast
);

    int   fail_cnt = 0;
    int   w_beat;    // beat index inside the W burst
    logic in_rst;

    always_ff @(posedge clk) begin
        if (!rstn)
            w_beat <= 0;
        else if (wvalid && wready)
            w_beat <= (w_beat + 1) % `L2_LINE_BEATS;
    end

    always_ff @(posedge clk) begin
        in_rst <= !rstn;
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin $error("arvalid or araddr changed before arready"); fail_cnt++; end

    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin $error("awvalid or awaddr changed before awready"); fail_cnt++; end

    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        wvalid && !wready |=> wvalid)
        else begin $error("wvalid dropped before wready"); fail_cnt++; end

    wlast_pos: assert property (@(posedge clk) disable iff (!rstn)
        wvalid |-> wlast == (w_beat == `L2_LINE_BEATS - 1))
        else begin $error("wlast not on the last W beat"); fail_cnt++; end

    rst_quiet: assert property (@(posedge clk)
        in_rst && !rstn |-> !arvalid && !awvalid && !wvalid)
        else begin $error("valid high during reset"); fail_cnt++; end

endmodule

bind l2_mem_port l2_mem_port_checker u_checker (
    .clk     (clk),
    .rstn    (rstn),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wvalid  (wvalid),
    .wready  (wready),
    .wlast   (wlast)
);

/* testbench/tb_l2_mem_port.sv */
// L2 memory port testbench
`include "l2_axi_settings.svh"

module tb_l2_mem_port;
    import l2_axi_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int W = `L2_WORD_W;
    localparam int BEATS = `L2_LINE_BEATS;

    logic     clk, rstn;
    logic     refill_req, refill_busy, refill_done, refill_err;
    addr_t    refill_addr, wb_addr, araddr, awaddr;
    line_t    refill_line, wb_line;
    logic     wb_req, wb_busy, wb_done, wb_err;
    logic     cfg_fill_we;
    word_t    cfg_fill_data, rdata, wdata;
    err_cnt_t rd_err_cnt, wr_err_cnt;
    logic     arvalid, arready, rvalid, rready, rlast;
    logic     awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic [1:0] rresp, bresp;

    // slave memory and the expected contents
    word_t      mem [256];
    word_t      ref_mem [256];
    word_t      fill_model;
    int         err_rate;    // 0 never, n means one in n
    int         rd_left, rd_ptr, wr_ptr;
    logic [3:0] rd_err_mask; // error beats of the current refill
    logic       r_take, w_take, b_take, b_due, b_err_last;
    int         data_errs, to_errs;
    err_cnt_t   rd_exp, wr_exp;

    l2_mem_port u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic word_t init_word(input int i);
        return {i[7:0], 8'h5A, ~i[7:0], i[7:0] ^ 8'hC3};
    endfunction

    function automatic logic err_now();
        return err_rate != 0 && ($urandom % err_rate) == 0;
    endfunction

    function automatic addr_t line_addr(input int line);
        return addr_t'((line % 64) * 16 + $urandom % 16);   // random offset inside the line
    endfunction

    function automatic line_t rand_line();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // AXI slave, read side
    always @(posedge clk) begin
        r_take = rvalid && rready;
        if (arvalid && arready) begin
            rd_ptr = int'(araddr[9:2]);
            rd_left = BEATS;
            rd_err_mask = '0;
        end
        if (r_take) begin
            if (rresp[1])
                rd_err_mask[BEATS - rd_left] = 1'b1;
            rd_ptr++;
            rd_left--;
        end
        #1;
        arready = ($urandom % 3) != 0;
        if (!rvalid || r_take) begin
            rvalid = rd_left > 0 && ($urandom % 3) != 0;
            rresp = (rvalid && err_now()) ? 2'b10 : 2'b00;
            rdata = rresp[1] ? $urandom : mem[rd_ptr & 255];  // junk on error beats
            rlast = rd_left == 1;
        end
    end

    // AXI slave, write side
    always @(posedge clk) begin
        w_take = wvalid && wready;
        b_take = bvalid && bready;
        if (awvalid && awready)
            wr_ptr = int'(awaddr[9:2]);
        if (w_take) begin
            mem[wr_ptr & 255] = wdata;
            wr_ptr++;
            if (wlast)
                b_due = 1'b1;
        end
        if (b_take)
            b_err_last = bresp[1];
        #1;
        awready = ($urandom % 3) != 0;
        wready = ($urandom % 3) != 0;
        if (b_take)
            bvalid = 1'b0;
        if (b_due && !bvalid && ($urandom % 2) == 0) begin
            bvalid = 1'b1;
            bresp = err_now() ? 2'b10 : 2'b00;
            b_due = 1'b0;
        end
    end

    task automatic check_line(input l2_axi_pkg::line_t got, input l2_axi_pkg::line_t exp,
                              input string what);
        if (got !== exp) begin
            data_errs++;
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            data_errs++;
            $display("error at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input l2_axi_pkg::err_cnt_t got,
                               input l2_axi_pkg::err_cnt_t exp, input string what);
        if (got !== exp) begin
            data_errs++;
            $display("error at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic refill_and_check(input addr_t addr);
        line_t exp;
        int    base;
        int    t;
        int    i;
        refill_addr = addr;
        refill_req = 1'b1;
        @(posedge clk);
        #1;
        refill_req = 1'b0;
        check_flag(refill_busy, 1'b1, "refill_busy after request");
        if (refill_busy && ($urandom % 2) == 0) begin   // must be ignored
            refill_addr = $urandom;
            refill_req = 1'b1;
            @(posedge clk);
            #1;
            refill_req = 1'b0;
        end
        t = 0;
        while (!refill_done && t < TIMEOUT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (!refill_done) begin
            to_errs++;
            $display("refill of %h did not finish within %0d cycles", addr, TIMEOUT);
        end else begin
            base = int'(addr[9:4]) * BEATS;
            for (i = 0; i < BEATS; i++)
                exp[i*W +: W] = rd_err_mask[i] ? fill_model : ref_mem[base + i];
            rd_exp += $countones(rd_err_mask);
            check_flag(refill_busy, 1'b0, "refill_busy at done");
            check_line(refill_line, exp, "refill_line");
            check_flag(refill_err, |rd_err_mask, "refill_err");
        end
    endtask

    task automatic writeback_and_check(input addr_t addr, input line_t line);
        int base;
        int t;
        int i;
        base = int'(addr[9:4]) * BEATS;
        for (i = 0; i < BEATS; i++)
            ref_mem[base + i] = line[i*W +: W];
        wb_addr = addr;
        wb_line = line;
        wb_req = 1'b1;
        @(posedge clk);
        #1;
        wb_req = 1'b0;
        check_flag(wb_busy, 1'b1, "wb_busy after request");
        if (wb_busy && ($urandom % 2) == 0) begin
            wb_addr = $urandom;
            wb_line = rand_line();
            wb_req = 1'b1;
            @(posedge clk);
            #1;
            wb_req = 1'b0;
        end
        t = 0;
        while (!wb_done && t < TIMEOUT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (!wb_done) begin
            to_errs++;
            $display("writeback to %h did not finish within %0d cycles", addr, TIMEOUT);
        end else begin
            wr_exp += b_err_last;
            check_flag(wb_busy, 1'b0, "wb_busy at done");
            check_flag(wb_err, b_err_last, "wb_err");
        end
    endtask

    task automatic set_fill(input word_t w);
        cfg_fill_data = w;
        cfg_fill_we = 1'b1;
        @(posedge clk);
        #1;
        cfg_fill_we = 1'b0;
        fill_model = w;
    endtask

    initial begin
        int    i;
        int    n;
        addr_t ra;
        addr_t wa;
        void'($urandom(58981));
        rstn = 1'b0;
        refill_req = 1'b0;
        refill_addr = '0;
        wb_req = 1'b0;
        wb_addr = '0;
        wb_line = '0;
        cfg_fill_we = 1'b0;
        cfg_fill_data = '0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = 2'b00;
        rlast = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        bresp = 2'b00;
        b_due = 1'b0;
        b_err_last = 1'b0;
        rd_left = 0;
        err_rate = 0;
        fill_model = `L2_FILL_RESET;
        data_errs = 0;
        to_errs = 0;
        rd_exp = '0;
        wr_exp = '0;
        for (i = 0; i < 256; i++) begin
            mem[i] = init_word(i);
            ref_mem[i] = mem[i];
        end
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;
        check_count(rd_err_cnt, 0, "rd_err_cnt after reset");
        check_count(wr_err_cnt, 0, "wr_err_cnt after reset");

        refill_and_check(line_addr(3));
        writeback_and_check(line_addr(5), rand_line());
        refill_and_check(line_addr(5));

        // every beat and response fails
        err_rate = 1;
        refill_and_check(line_addr(7));
        set_fill($urandom);
        refill_and_check(line_addr(8));
        writeback_and_check(line_addr(9), rand_line());
        check_count(rd_err_cnt, rd_exp, "rd_err_cnt");
        check_count(wr_err_cnt, wr_exp, "wr_err_cnt");

        // overlapping traffic, halves swap each round
        err_rate = 8;
        for (n = 0; n < 24; n++) begin
            ra = line_addr((n % 2) * 32 + $urandom % 32);
            wa = line_addr((1 - n % 2) * 32 + $urandom % 32);
            fork
                refill_and_check(ra);
                writeback_and_check(wa, rand_line());
            join
        end
        check_count(rd_err_cnt, rd_exp, "rd_err_cnt");
        check_count(wr_err_cnt, wr_exp, "wr_err_cnt");

        $display("checks done: %0d data errors, %0d timeouts, %0d assertion failures",
                 data_errs, to_errs, u_dut.u_checker.fail_cnt);
        if (data_errs == 0 && to_errs == 0 && u_dut.u_checker.fail_cnt == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
